// File: bench/mf2_asserts.sv
// Multiface control checks
// Concurrent properties on the NMI request and the window enables

`timescale 1ns/1ps

module mf2_asserts
	import mf2_map_pkg::*;
(
	input logic       clk_sys,
	input logic       reset,
	input bus_event_t ev,
	input logic       nmi,
	input logic       rom_en,
	input logic       ram_en
);

	// NMI is only taken by the acknowledge fetch
	a_nmi_fall: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> $past(ev.m1_rise))
		else $error("nmi dropped without an opcode fetch");

	a_nmi_rise: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> $past(ev.key_rise))
		else $error("nmi raised without a freeze key press");

	a_one_window: assert property (@(posedge clk_sys) !(rom_en && ram_en))
		else $error("rom_en and ram_en high together");

endmodule

bind mf2_control mf2_asserts u_asserts (
	.clk_sys(clk_sys), .reset(reset), .ev(ev),
	.nmi(nmi), .rom_en(rom_en), .ram_en(ram_en)
);

// File: bench/mf2_vectors.txt
// Columns: op_addr_data_dout_flags_rnd, all hex
// op 1 io write, 2 m1 fetch, 3 mem read, 4 mem write, 5 key, 6 mode+reset (data = mode)
// flags = {nmi, rom_en, ram_en}; rnd 1 = random data in the second pass
6_0000_00_ff_0_0
3_2000_00_ff_0_0
// Freeze and NMI acknowledge
5_8000_00_ff_4_0
2_0066_00_ff_2_0
3_0100_00_ff_2_0
// Shadow RAM while paged
4_2345_a5_ff_1_1
3_2345_00_a5_1_1
4_3001_5a_ff_1_1
3_3001_00_5a_1_1
// Gate array pen 3 then ink
1_7f00_03_ff_0_0
1_7f00_54_ff_0_0
3_3f93_00_54_1_0
3_3fcf_00_03_1_0
// CRTC register 5
1_bc00_05_ff_0_0
1_bd00_21_ff_0_0
3_3db5_00_21_1_0
// PPI and upper ROM
1_f700_82_ff_0_0
3_37ff_00_82_1_0
1_df00_07_ff_0_0
3_3aac_00_07_1_0
// Page port out and in
1_feea_00_ff_0_0
3_3001_00_ff_0_0
1_fee8_00_ff_0_0
3_3001_00_5a_1_1
// Hide, then the page port no longer pages in
2_0065_00_ff_2_0
1_fee8_00_ff_0_0
3_3001_00_ff_0_0
1_fee8_00_ff_0_0
3_3001_00_ff_0_0
// Disabled mode
6_0000_02_ff_0_0
5_8000_00_ff_0_0
1_fee8_00_ff_0_0
3_2000_00_ff_0_0
// Hidden mode
6_0000_01_ff_0_0
1_fee8_00_ff_0_0
3_3001_00_ff_0_0
5_8000_00_ff_4_0
2_0066_00_ff_2_0
3_3001_00_5a_1_1
1_feea_00_ff_0_0
1_fee8_00_ff_0_0
3_3f93_00_54_1_0
0_0000_00_00_0_0

// File: bench/tb_clock.sv
// Testbench clock and power-on reset
// 10 ns clock, reset held for the first two rising edges

`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

// File: bench/tb_mf2.sv
// Multiface Two testbench
// Replays bench/mf2_vectors.txt twice, the second time with
// random shadow RAM data, and checks dout and the window flags

`timescale 1ns/1ps

module tb_mf2
	import cpu_bus_pkg::*, mf2_map_pkg::*;
();

	typedef enum logic [3:0] {
		OP_END    = 4'd0,
		OP_IO_WR  = 4'd1,
		OP_M1     = 4'd2,
		OP_MEM_RD = 4'd3,
		OP_MEM_WR = 4'd4,
		OP_KEY    = 4'd5,
		OP_MODE   = 4'd6   // Mode switch with reset
	} vec_op_e;

	typedef struct packed {
		logic nmi;
		logic rom_en;
		logic ram_en;
	} flag_set_t;

	localparam int VEC_MAX       = 64;
	localparam int RESET_TIMEOUT = 20;

	logic        clk_sys;
	logic        por_reset;
	logic        mode_reset;
	logic        reset;
	cpu_bus_t    bus;
	logic        freeze_key;
	mf2_mode_e   mode;
	logic        nmi;
	logic        rom_en;
	logic        ram_en;
	cpu_data_t   dout;
	logic [43:0] vec_mem [VEC_MAX];   // op_addr_data_dout_flags_rnd
	int          vec_count;
	logic [31:0] rand_state;
	cpu_data_t   last_rand;

	assign reset = por_reset | mode_reset;

	tb_clock u_clock (.clk_sys(clk_sys), .reset(por_reset));

	mf2_top dut (
		.clk_sys(clk_sys), .reset(reset), .bus(bus), .freeze_key(freeze_key),
		.mode(mode), .nmi(nmi), .rom_en(rom_en), .ram_en(ram_en), .dout(dout)
	);

	//////////////////////////////
	// Helpers
	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic cpu_bus_t bus_for_op(input vec_op_e op, input cpu_addr_t a,
			input cpu_data_t d);
		cpu_bus_t b;
		b      = '0;
		b.addr = a;
		b.dout = d;
		case (op)
			OP_IO_WR: begin
				b.iorq = 1'b1;
				b.wr   = 1'b1;
			end
			OP_M1: begin
				b.m1     = 1'b1;
				b.rd     = 1'b1;
				b.mem_rd = 1'b1;
			end
			OP_MEM_RD: begin
				b.rd     = 1'b1;
				b.mem_rd = 1'b1;
			end
			OP_MEM_WR: begin
				b.wr     = 1'b1;
				b.mem_wr = 1'b1;
			end
			default: ;   // Key press and idle leave all strobes low
		endcase
		return b;
	endfunction

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_data(input cpu_data_t got, input cpu_data_t exp,
			input cpu_addr_t addr);
		if (got !== exp)
			fail_stop($sformatf("ERR %0t: dout at %04h is %02h, expected %02h",
				$time, addr, got, exp));
	endtask

	task automatic compare_flags(input flag_set_t got, input flag_set_t exp,
			input cpu_addr_t addr);
		if (got !== exp)
			fail_stop($sformatf("ERR %0t: nmi/rom_en/ram_en after %04h is %03b, expected %03b",
				$time, addr, got, exp));
	endtask

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		@(negedge clk_sys);
		while (reset) begin
			cycles++;
			if (cycles > RESET_TIMEOUT)
				fail_stop("Reset did not release within the expected time");
			@(negedge clk_sys);
		end
	endtask

	//////////////////////////////
	// Operations
	task automatic switch_mode(input mf2_mode_e m, input cpu_data_t exp_d,
			input flag_set_t exp_f);
		@(posedge clk_sys);
		mode       <= m;
		mode_reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		mode_reset <= 1'b0;
		wait_reset_done();
		compare_data(dout, exp_d, bus.addr);
		compare_flags(flag_set_t'({nmi, rom_en, ram_en}), exp_f, bus.addr);
	endtask

	// Strobe held 3 cycles, then 1 idle cycle
	task automatic run_bus_op(input vec_op_e op, input cpu_addr_t a, input cpu_data_t d,
			input cpu_data_t exp_d, input flag_set_t exp_f);
		@(posedge clk_sys);
		bus        <= bus_for_op(op, a, d);
		freeze_key <= (op == OP_KEY);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		compare_data(dout, exp_d, a);   // Third strobe cycle
		@(posedge clk_sys);
		bus        <= bus_for_op(OP_END, a, d);
		freeze_key <= 1'b0;
		@(negedge clk_sys);
		compare_flags(flag_set_t'({nmi, rom_en, ram_en}), exp_f, a);
	endtask

	task automatic run_vectors(input bit use_rand);
		logic [43:0] v;
		vec_op_e     op;
		cpu_addr_t   a;
		cpu_data_t   d;
		cpu_data_t   exp_d;
		flag_set_t   exp_f;
		for (int i = 0; i < vec_count; i++) begin
			v     = vec_mem[i];
			op    = vec_op_e'(v[43:40]);
			a     = v[39:24];
			d     = v[23:16];
			exp_d = v[15:8];
			exp_f = flag_set_t'(v[6:4]);
			if (use_rand && v[0]) begin
				if (op == OP_MEM_WR) begin
					rand_state = next_random(rand_state);
					last_rand  = rand_state[7:0];
					d          = last_rand;
				end else if (op == OP_MEM_RD) begin
					exp_d = last_rand;
				end
			end
			if (op == OP_MODE)
				switch_mode(mf2_mode_e'(d[1:0]), exp_d, exp_f);
			else
				run_bus_op(op, a, d, exp_d, exp_f);
		end
	endtask

	initial begin
		bus        = '0;
		freeze_key = 1'b0;
		mode       = MF2_ENABLED;
		mode_reset = 1'b0;
		rand_state = 32'h53ba;
		last_rand  = '0;
		vec_count  = 0;
		for (int i = 0; i < VEC_MAX; i++)
			vec_mem[i] = '0;
		$readmemh("bench/mf2_vectors.txt", vec_mem);
		while (vec_count < VEC_MAX && vec_mem[vec_count][43:40] != 4'h0)
			vec_count++;
		if (vec_count == 0)
			fail_stop("No vectors were read from bench/mf2_vectors.txt");
		wait_reset_done();
		run_vectors(1'b0);
		run_vectors(1'b1);   // Same sequence with random RAM data
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: hw/cpu_bus_pkg.sv
// CPU bus package
// One sample of the Z80-style CPU bus, with the
// address and data types and the idle bus value

package cpu_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] cpu_addr_t;
	typedef logic [DATA_W-1:0] cpu_data_t;

	// Undriven data bus reads as all ones
	localparam cpu_data_t DATA_IDLE = 8'hFF;

	// All strobes active high
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t dout;     // CPU write data
		logic      rd;
		logic      wr;
		logic      iorq;
		logic      m1;
		logic      mem_rd;   // Memory read cycle
		logic      mem_wr;   // Memory write cycle
	} cpu_bus_t;

endpackage

// File: hw/mf2_bus_events.sv
// Multiface bus event detector
// Finds rising edges of I/O write, opcode fetch and the freeze key,
// and decodes the page port once for the later stages

`timescale 1ns/1ps

module mf2_bus_events
	import cpu_bus_pkg::*, mf2_map_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic       freeze_key,
	output bus_event_t ev
);

	logic io_wr;
	logic fetch;
	logic io_wr_q;
	logic fetch_q;
	logic key_q;

	assign io_wr = bus.iorq & bus.wr;
	// Interrupt acknowledge carries iorq so only opcode fetches count
	assign fetch = bus.m1 & bus.rd & ~bus.iorq;

	//////////////////////////////
	// Previous levels
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			fetch_q <= 1'b0;
			key_q   <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			fetch_q <= fetch;
			key_q   <= freeze_key;
		end
	end

	always_comb begin
		ev.io_wr_rise = io_wr & ~io_wr_q;
		ev.m1_rise    = fetch & ~fetch_q;
		ev.key_rise   = freeze_key & ~key_q;
		ev.port_page  = (bus.addr[15:2] == PAGE_PORT_BASE);
		ev.page_out   = bus.addr[1];   // FEEA pages out
		ev.addr       = bus.addr;
		ev.data       = bus.dout;
	end

endmodule

// File: hw/mf2_control.sv
// Multiface control
// NMI request, paging and hiding of the unit,
// and the ROM / RAM window enables

`timescale 1ns/1ps

module mf2_control
	import cpu_bus_pkg::*, mf2_map_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  bus_event_t ev,
	input  mf2_mode_e  mode,
	input  cpu_addr_t  addr,
	output logic       nmi,
	output logic       paged,
	output logic       rom_en,
	output logic       ram_en
);

	mf2_state_e state;
	mf2_mode_e  mode_q;
	logic       hidden;   // Blocks paging in through the port
	logic       nmi_ack;
	logic       hide_hit;
	logic       port_wr;
	logic       page_in_ok;

	assign nmi_ack    = ev.m1_rise && (ev.addr == NMI_VECTOR);
	assign hide_hit   = ev.m1_rise && (ev.addr == HIDE_VECTOR);
	assign port_wr    = ev.io_wr_rise && ev.port_page;
	assign page_in_ok = !ev.page_out && !hidden && (mode_q != MF2_DISABLED);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= ST_IDLE;
			mode_q <= mode;   // Setup switch
			hidden <= (mode != MF2_ENABLED);
		end else begin
			case (state)
				ST_IDLE: begin
					if (port_wr && page_in_ok)
						state <= ST_PAGED;
					else if (ev.key_rise && mode_q != MF2_DISABLED)
						state <= ST_NMI_PENDING;
				end
				ST_NMI_PENDING: begin
					// Port writes wait until the NMI is taken
					if (nmi_ack) begin
						state  <= ST_PAGED;
						hidden <= 1'b0;
					end
				end
				ST_PAGED: begin
					if (hide_hit) begin
						state  <= ST_PAGED_HIDDEN;
						hidden <= 1'b1;
					end else if (port_wr) begin
						state <= page_in_ok ? ST_PAGED : ST_IDLE;
					end
				end
				ST_PAGED_HIDDEN: begin
					if (port_wr)
						state <= ST_IDLE;   // Hidden unit only pages out
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign nmi    = (state == ST_NMI_PENDING);
	assign paged  = (state == ST_PAGED) || (state == ST_PAGED_HIDDEN);
	assign rom_en = paged && (addr[15:13] == ROM_WINDOW);
	assign ram_en = paged && (addr[15:13] == RAM_WINDOW);

endmodule

// File: hw/mf2_map_pkg.sv
// Multiface Two map package
// Memory windows, trap vectors, I/O ports, shadow slots in the
// 8 KB RAM, and the state, mode and gate-array command types

package mf2_map_pkg;
	import cpu_bus_pkg::*;

	localparam int SHADOW_AW    = 13;
	localparam int SHADOW_DEPTH = 8192;

	typedef logic [SHADOW_AW-1:0] shadow_addr_t;

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_NMI_PENDING,
		ST_PAGED,
		ST_PAGED_HIDDEN
	} mf2_state_e;

	// Gate-array command in data bits 7:6
	typedef enum logic [1:0] {
		GA_PEN_SEL = 2'b00,
		GA_INK     = 2'b01,
		GA_MODE    = 2'b10,
		GA_BANK    = 2'b11
	} ga_cmd_e;

	typedef struct packed {
		logic      io_wr_rise;
		logic      m1_rise;
		logic      key_rise;
		logic      port_page;   // 0xFEE8 / 0xFEEA
		logic      page_out;    // Address bit 1 of the page port
		cpu_addr_t addr;
		cpu_data_t data;
	} bus_event_t;

	localparam cpu_addr_t   NMI_VECTOR     = 16'h0066;
	localparam cpu_addr_t   HIDE_VECTOR    = 16'h0065;
	localparam logic [13:0] PAGE_PORT_BASE = 14'h3FBA;   // 0xFEE8 >> 2
	localparam logic [2:0]  ROM_WINDOW     = 3'b000;
	localparam logic [2:0]  RAM_WINDOW     = 3'b001;

	//////////////////////////////
	// Shadow slots
	localparam shadow_addr_t SLOT_PEN_INDEX = 13'h1FCF;
	localparam shadow_addr_t SLOT_PEN_BASE  = 13'h1F90;
	localparam shadow_addr_t SLOT_BORDER    = 13'h1FDF;
	localparam shadow_addr_t SLOT_MODE      = 13'h1FEF;
	localparam shadow_addr_t SLOT_BANK      = 13'h1FFF;
	localparam shadow_addr_t SLOT_CRTC_SEL  = 13'h1CFF;
	localparam shadow_addr_t SLOT_CRTC_BASE = 13'h1DB0;
	localparam shadow_addr_t SLOT_PPI       = 13'h17FF;
	localparam shadow_addr_t SLOT_UROM      = 13'h1AAC;

	// Port high bytes
	localparam cpu_data_t PORT_GA        = 8'h7F;
	localparam cpu_data_t PORT_CRTC_SEL  = 8'hBC;
	localparam cpu_data_t PORT_CRTC_DATA = 8'hBD;
	localparam cpu_data_t PORT_PPI       = 8'hF7;
	localparam cpu_data_t PORT_UROM      = 8'hDF;

endpackage

// File: hw/mf2_shadow_ram.sv
// Multiface shadow RAM
// 8 KB single port RAM with write-through read data,
// driven onto the bus only for an enabled memory read

`timescale 1ns/1ps

module mf2_shadow_ram
	import cpu_bus_pkg::*, mf2_map_pkg::*;
(
	input  logic         clk_sys,
	input  shadow_addr_t ram_addr,
	input  cpu_data_t    ram_din,
	input  logic         ram_we,
	input  logic         ram_en,
	input  logic         mem_rd,
	output cpu_data_t    dout
);

	cpu_data_t mem [SHADOW_DEPTH];
	cpu_data_t rd_q;

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_din;
			rd_q          <= ram_din;   // Write-through
		end else begin
			rd_q <= mem[ram_addr];
		end
	end

	assign dout = (mem_rd && ram_en) ? rd_q : DATA_IDLE;

endmodule

// File: hw/mf2_store_map.sv
// Multiface shadow store mapper
// Chooses the shadow RAM address and write for every bus cycle.
// Hardware register writes land in fixed slots, CPU accesses
// in the RAM window use the low address bits

`timescale 1ns/1ps

module mf2_store_map
	import cpu_bus_pkg::*, mf2_map_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  bus_event_t   ev,
	input  cpu_bus_t     bus,
	input  logic         paged,
	output shadow_addr_t ram_addr,
	output cpu_data_t    ram_din,
	output logic         ram_we
);

	logic [4:0]   pen_index;   // Bit 4 selects the border
	logic [3:0]   crtc_reg;
	ga_cmd_e      ga_cmd;
	shadow_addr_t store_addr;
	logic         store_hit;
	logic         mem_hit;

	assign ga_cmd  = ga_cmd_e'(ev.data[7:6]);
	assign mem_hit = bus.mem_wr && paged && (bus.addr[15:13] == RAM_WINDOW);

	//////////////////////////////
	// Port to slot decode
	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (ev.addr[15:8])
			PORT_GA: begin
				case (ga_cmd)
					GA_PEN_SEL: store_addr = SLOT_PEN_INDEX;
					GA_INK: begin
						if (pen_index[4])
							store_addr = SLOT_BORDER;
						else
							store_addr = SLOT_PEN_BASE | {9'd0, pen_index[3:0]};
					end
					GA_MODE: store_addr = SLOT_MODE;
					GA_BANK: store_addr = SLOT_BANK;
					default: store_addr = SLOT_BANK;
				endcase
			end
			PORT_CRTC_SEL:  store_addr = SLOT_CRTC_SEL;
			PORT_CRTC_DATA: store_addr = SLOT_CRTC_BASE | {9'd0, crtc_reg};
			PORT_PPI:       store_addr = SLOT_PPI;
			PORT_UROM:      store_addr = SLOT_UROM;
			default:        store_hit  = 1'b0;
		endcase
	end

	// Tracked pen and CRTC register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (ev.io_wr_rise && !ev.port_page) begin
			if (ev.addr[15:8] == PORT_GA && ga_cmd == GA_PEN_SEL)
				pen_index <= ev.data[4:0];
			if (ev.addr[15:8] == PORT_CRTC_SEL)
				crtc_reg <= ev.data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= (ev.io_wr_rise && !ev.port_page && store_hit) || mem_hit;
	end

	// Address and data
	always_ff @(posedge clk_sys) begin
		if (ev.io_wr_rise && !ev.port_page && store_hit) begin
			ram_addr <= store_addr;
			ram_din  <= ev.data;
		end else begin
			ram_addr <= bus.addr[SHADOW_AW-1:0];   // CPU read or write
			ram_din  <= bus.dout;
		end
	end

endmodule

// File: hw/mf2_top.sv
// Multiface Two top level
// Bus event decode, control and store mapping, then shadow RAM

`timescale 1ns/1ps

module mf2_top
	import cpu_bus_pkg::*, mf2_map_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  bus,
	input  logic      freeze_key,
	input  mf2_mode_e mode,       // Sampled in reset
	output logic      nmi,
	output logic      rom_en,     // Outside ROM supplies 0x0000-0x1FFF
	output logic      ram_en,
	output cpu_data_t dout
);

	bus_event_t   ev;
	logic         paged;
	shadow_addr_t ram_addr;
	cpu_data_t    ram_din;
	logic         ram_we;

	mf2_bus_events u_events (
		.clk_sys(clk_sys), .reset(reset), .bus(bus), .freeze_key(freeze_key), .ev(ev)
	);

	mf2_control u_control (
		.clk_sys(clk_sys), .reset(reset), .ev(ev), .mode(mode), .addr(bus.addr),
		.nmi(nmi), .paged(paged), .rom_en(rom_en), .ram_en(ram_en)
	);

	mf2_store_map u_store (
		.clk_sys(clk_sys), .reset(reset), .ev(ev), .bus(bus), .paged(paged),
		.ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we)
	);

	mf2_shadow_ram u_ram (
		.clk_sys(clk_sys), .ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we),
		.ram_en(ram_en), .mem_rd(bus.mem_rd), .dout(dout)
	);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the Multiface Two testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_mf2 -o sim_mf2
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mf2
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
fi
exit $status

// File: src.f
hw/cpu_bus_pkg.sv
hw/mf2_map_pkg.sv
hw/mf2_bus_events.sv
hw/mf2_control.sv
hw/mf2_store_map.sv
hw/mf2_shadow_ram.sv
hw/mf2_top.sv
bench/tb_clock.sv
bench/mf2_asserts.sv
bench/tb_mf2.sv
